//--- opnd_pkg.sv
package opnd_pkg;

  // Width of every data and address word on the operand paths
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [2:0]        reg_sel_t;
  typedef logic [1:0]        scale_t;
  typedef logic [3:0]        opnd_form_t;
  typedef logic [1:0]        dest_kind_t;

  // Operand forms, named as operand 0 then operand 1
  // Code 0 is left free so an idle bus decodes to no operands
  localparam opnd_form_t FORM_MODRM_RM_REG = 4'd1;
  localparam opnd_form_t FORM_MODRM_REG_RM = 4'd2;
  localparam opnd_form_t FORM_MODRM_RM_IMM = 4'd3;
  localparam opnd_form_t FORM_REG          = 4'd4;
  localparam opnd_form_t FORM_REG_IMM      = 4'd5;
  localparam opnd_form_t FORM_EAX_IMM      = 4'd6;
  localparam opnd_form_t FORM_IMM          = 4'd7;

  // General register numbers in x86 encoding order
  localparam reg_sel_t REG_EAX = 3'd0;
  localparam reg_sel_t REG_ECX = 3'd1;
  localparam reg_sel_t REG_EDX = 3'd2;
  localparam reg_sel_t REG_EBX = 3'd3;
  localparam reg_sel_t REG_ESP = 3'd4;
  localparam reg_sel_t REG_EBP = 3'd5;
  localparam reg_sel_t REG_ESI = 3'd6;
  localparam reg_sel_t REG_EDI = 3'd7;

  // Destination kinds are one-hot so a consumer can test a single bit
  localparam dest_kind_t DEST_NONE = 2'b00;
  localparam dest_kind_t DEST_REG  = 2'b01;
  localparam dest_kind_t DEST_MEM  = 2'b10;

  // Eight-way register read, shared by the operand and address paths
  function automatic word_t reg_read(input reg_sel_t sel,
                                     input word_t eax, input word_t ecx,
                                     input word_t edx, input word_t ebx,
                                     input word_t esp, input word_t ebp,
                                     input word_t esi, input word_t edi);
    case (sel)
      REG_EAX: return eax;
      REG_ECX: return ecx;
      REG_EDX: return edx;
      REG_EBX: return ebx;
      REG_ESP: return esp;
      REG_EBP: return ebp;
      REG_ESI: return esi;
      default: return edi;
    endcase
  endfunction

endpackage

//--- modrm_fields.sv
`timescale 1ns/1ps

module modrm_fields #(
  parameter int INSTR_BYTES = 11
) (
  input  logic [INSTR_BYTES*8-1:0] instr,
  input  opnd_pkg::opnd_form_t     opnd_form,
  input  logic                     imm_1byte,
  output logic [7:0]               modrm,
  output logic [7:0]               sib,
  output opnd_pkg::word_t          disp,
  output opnd_pkg::word_t          imm,
  output logic                     has_sib,
  output logic                     rm_is_direct,
  output logic                     disp_is_absolute,
  output logic [3:0]               body_len
);
  import opnd_pkg::*;

  logic                     has_modrm;
  logic                     has_imm;
  logic [3:0]               disp_len;
  logic [3:0]               imm_len;
  logic [3:0]               disp_off;
  logic [3:0]               imm_off;
  logic [INSTR_BYTES*8-1:0] disp_bytes;
  logic [INSTR_BYTES*8-1:0] imm_bytes;

  // Byte 0 is the opcode, so ModR/M and SIB sit at fixed places behind it
  assign modrm = instr[15:8];
  assign sib   = instr[23:16];

  assign has_modrm = (opnd_form == FORM_MODRM_RM_REG) ||
                     (opnd_form == FORM_MODRM_REG_RM) ||
                     (opnd_form == FORM_MODRM_RM_IMM);
  assign has_imm   = (opnd_form == FORM_MODRM_RM_IMM) || (opnd_form == FORM_REG_IMM) ||
                     (opnd_form == FORM_EAX_IMM) || (opnd_form == FORM_IMM);

  // mod == 3 names a register, anything else a memory operand
  assign rm_is_direct = has_modrm && (modrm[7:6] == 2'b11);
  // rm == 4 in a memory form escapes to a SIB byte
  assign has_sib      = has_modrm && (modrm[7:6] != 2'b11) && (modrm[2:0] == 3'b100);

  // Displacement length follows mod, with the two disp32-only cases under mod 0
  always_comb begin
    disp_len         = 4'd0;
    disp_is_absolute = 1'b0;
    if (has_modrm) begin
      case (modrm[7:6])
        2'b01: disp_len = 4'd1;
        2'b10: disp_len = 4'd4;
        2'b00: begin
          // rm 5 alone, or SIB base 5, drops the base for a bare disp32
          if ((!has_sib && modrm[2:0] == 3'b101) || (has_sib && sib[2:0] == 3'b101)) begin
            disp_len         = 4'd4;
            disp_is_absolute = 1'b1;
          end
        end
        default: disp_len = 4'd0;
      endcase
    end
  end

  assign imm_len = !has_imm ? 4'd0 : (imm_1byte ? 4'd1 : 4'd4);

  // Fields are packed back to back after the opcode
  assign disp_off = 4'd2 + {3'b000, has_sib};
  assign imm_off  = 4'd1 + {3'b000, has_modrm} + {3'b000, has_sib} + disp_len;

  assign disp_bytes = instr >> {disp_off, 3'b000};
  assign imm_bytes  = instr >> {imm_off, 3'b000};

  // Short displacements and short immediates are both sign-extended
  assign disp = (disp_len == 4'd1) ? {{24{disp_bytes[7]}}, disp_bytes[7:0]} :
                (disp_len == 4'd4) ? disp_bytes[31:0] : '0;
  assign imm  = (imm_len == 4'd1) ? {{24{imm_bytes[7]}}, imm_bytes[7:0]} :
                (imm_len == 4'd4) ? imm_bytes[31:0] : '0;

  // The opcode byte itself is not counted in the body length
  assign body_len = {3'b000, has_modrm} + {3'b000, has_sib} + disp_len + imm_len;

endmodule

//--- reg_operand_select.sv
`timescale 1ns/1ps

module reg_operand_select (
  input  opnd_pkg::reg_sel_t   instr_low,
  input  opnd_pkg::opnd_form_t opnd_form,
  input  logic [7:0]           modrm,
  input  logic                 rm_is_direct,
  input  opnd_pkg::word_t      eax,
  input  opnd_pkg::word_t      ecx,
  input  opnd_pkg::word_t      edx,
  input  opnd_pkg::word_t      ebx,
  input  opnd_pkg::word_t      esp,
  input  opnd_pkg::word_t      ebp,
  input  opnd_pkg::word_t      esi,
  input  opnd_pkg::word_t      edi,
  output opnd_pkg::reg_sel_t   opnd0_regsel,
  output opnd_pkg::reg_sel_t   opnd1_regsel,
  output opnd_pkg::word_t      opnd0_regval,
  output opnd_pkg::word_t      opnd1_regval
);
  import opnd_pkg::*;

  logic rm_first;
  logic reg_first;

  // Forms where ModR/M.rm describes operand 0, and where ModR/M.reg does
  assign rm_first  = (opnd_form == FORM_MODRM_RM_REG) || (opnd_form == FORM_MODRM_RM_IMM);
  assign reg_first = (opnd_form == FORM_MODRM_REG_RM);

  // Operand 0 looks at opcode bits first, then rm, then reg, then implicit EAX
  assign opnd0_regsel = ((opnd_form == FORM_REG) || (opnd_form == FORM_REG_IMM)) ? instr_low :
                        (rm_first && rm_is_direct) ? modrm[2:0] :
                        reg_first                  ? modrm[5:3] : REG_EAX;

  // Operand 1 only ever comes out of ModR/M
  // A memory rm leaves the selector at zero since no register is read
  assign opnd1_regsel = (reg_first && rm_is_direct)        ? modrm[2:0] :
                        (opnd_form == FORM_MODRM_RM_REG)   ? modrm[5:3] : REG_EAX;

  assign opnd0_regval = reg_read(opnd0_regsel, eax, ecx, edx, ebx, esp, ebp, esi, edi);
  assign opnd1_regval = reg_read(opnd1_regsel, eax, ecx, edx, ebx, esp, ebp, esi, edi);

endmodule

//--- effective_address.sv
`timescale 1ns/1ps

module effective_address (
  input  logic [7:0]      modrm,
  input  logic [7:0]      sib,
  input  logic            has_sib,
  input  logic            disp_is_absolute,
  input  opnd_pkg::word_t disp,
  input  opnd_pkg::word_t eax,
  input  opnd_pkg::word_t ecx,
  input  opnd_pkg::word_t edx,
  input  opnd_pkg::word_t ebx,
  input  opnd_pkg::word_t esp,
  input  opnd_pkg::word_t ebp,
  input  opnd_pkg::word_t esi,
  input  opnd_pkg::word_t edi,
  output opnd_pkg::word_t mem_addr
);
  import opnd_pkg::*;

  reg_sel_t base_sel;
  reg_sel_t index_sel;
  scale_t   scale;
  logic     no_index;
  word_t    base;
  word_t    index;

  // With SIB the base comes from SIB.base, otherwise straight from ModR/M.rm
  assign base_sel  = has_sib ? sib[2:0] : modrm[2:0];
  assign index_sel = sib[5:3];

  // Without SIB the scale field is meaningless, so force a factor of one
  assign scale = has_sib ? sib[7:6] : 2'b00;

  // SIB.index 4 encodes no index, which is how ESP is kept out of scaling
  assign no_index = !has_sib || (index_sel == REG_ESP);

  // The disp32-only encodings have no base register at all
  assign base  = disp_is_absolute ? '0 :
                 reg_read(base_sel, eax, ecx, edx, ebx, esp, ebp, esi, edi);
  assign index = no_index ? '0 :
                 reg_read(index_sel, eax, ecx, edx, ebx, esp, ebp, esi, edi);

  // One AGU covers the single memory operand ModR/M can describe
  // disp arrives as zero when mod selects no displacement
  assign mem_addr = base + (index << scale) + disp;

endmodule

//--- mem_hint_match.sv
`timescale 1ns/1ps

module mem_hint_match (
  input  opnd_pkg::word_t mem_addr,
  input  logic            hint1_is_write,
  input  opnd_pkg::word_t hint1_address,
  input  opnd_pkg::word_t hint1_data,
  input  logic            hint2_is_write,
  input  opnd_pkg::word_t hint2_address,
  input  opnd_pkg::word_t hint2_data,
  output opnd_pkg::word_t mem_value
);
  import opnd_pkg::*;

  logic hint1_hit;
  logic hint2_hit;

  // Only read hints can supply data, and only for the exact address
  assign hint1_hit = !hint1_is_write && (hint1_address == mem_addr);
  assign hint2_hit = !hint2_is_write && (hint2_address == mem_addr);

  // Hint 1 wins when both match; a miss reads as zero
  assign mem_value = hint1_hit ? hint1_data :
                     hint2_hit ? hint2_data : word_t'(0);

endmodule

//--- operand_select.sv
`timescale 1ns/1ps

module operand_select (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  opnd_pkg::opnd_form_t opnd_form,
  input  logic                 is_lea,
  input  logic                 opnd0_is_write,
  input  logic                 opnd1_is_write,
  input  logic                 rm_is_direct,
  input  opnd_pkg::word_t      imm,
  input  opnd_pkg::reg_sel_t   opnd0_regsel,
  input  opnd_pkg::reg_sel_t   opnd1_regsel,
  input  opnd_pkg::word_t      opnd0_regval,
  input  opnd_pkg::word_t      opnd1_regval,
  input  opnd_pkg::word_t      mem_addr,
  input  opnd_pkg::word_t      mem_value,
  input  logic [3:0]           body_len,
  output logic                 out_valid,
  output opnd_pkg::word_t      opnd0_r,
  output opnd_pkg::word_t      opnd1_r,
  output opnd_pkg::dest_kind_t dest0_kind,
  output opnd_pkg::dest_kind_t dest1_kind,
  output opnd_pkg::word_t      dest0_sel,
  output opnd_pkg::word_t      dest1_sel,
  output logic [3:0]           instr_body_len
);
  import opnd_pkg::*;

  logic       rm_first;
  logic       opnd0_is_reg;
  logic       opnd0_is_mem;
  logic       opnd1_is_reg;
  logic       opnd1_is_mem;
  logic       opnd1_is_imm;
  word_t      mem_rd;
  word_t      opnd0_val;
  word_t      opnd1_val;
  dest_kind_t dest0_kind_d;
  dest_kind_t dest1_kind_d;
  word_t      dest0_sel_d;
  word_t      dest1_sel_d;

  assign rm_first = (opnd_form == FORM_MODRM_RM_REG) || (opnd_form == FORM_MODRM_RM_IMM);

  // Classify each operand from the form; rm splits on the mod field
  assign opnd0_is_reg = (opnd_form == FORM_REG) || (opnd_form == FORM_REG_IMM) ||
                        (opnd_form == FORM_EAX_IMM) || (opnd_form == FORM_MODRM_REG_RM) ||
                        (rm_first && rm_is_direct);
  assign opnd0_is_mem = rm_first && !rm_is_direct;
  assign opnd1_is_reg = (opnd_form == FORM_MODRM_RM_REG) ||
                        ((opnd_form == FORM_MODRM_REG_RM) && rm_is_direct);
  assign opnd1_is_mem = (opnd_form == FORM_MODRM_REG_RM) && !rm_is_direct;
  assign opnd1_is_imm = (opnd_form == FORM_MODRM_RM_IMM) || (opnd_form == FORM_REG_IMM) ||
                        (opnd_form == FORM_EAX_IMM);

  // LEA goes through the AGU but hands back the address instead of memory data
  assign mem_rd = is_lea ? mem_addr : mem_value;

  assign opnd0_val = opnd0_is_reg ? opnd0_regval :
                     opnd0_is_mem ? mem_rd :
                     (opnd_form == FORM_IMM) ? imm : '0;
  assign opnd1_val = opnd1_is_reg ? opnd1_regval :
                     opnd1_is_mem ? mem_rd :
                     opnd1_is_imm ? imm : '0;

  // Register destinations carry a one-hot register mask in the low byte
  assign dest0_kind_d = !opnd0_is_write ? DEST_NONE :
                        opnd0_is_reg ? DEST_REG : opnd0_is_mem ? DEST_MEM : DEST_NONE;
  assign dest1_kind_d = !opnd1_is_write ? DEST_NONE :
                        opnd1_is_reg ? DEST_REG : opnd1_is_mem ? DEST_MEM : DEST_NONE;

  assign dest0_sel_d = (dest0_kind_d == DEST_REG) ? {24'd0, 8'd1 << opnd0_regsel} :
                       (dest0_kind_d == DEST_MEM) ? mem_addr : '0;
  assign dest1_sel_d = (dest1_kind_d == DEST_REG) ? {24'd0, 8'd1 << opnd1_regsel} :
                       (dest1_kind_d == DEST_MEM) ? mem_addr : '0;

  // The strobe follows instr_valid by exactly one edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= instr_valid;
    end
  end

  // Results load only on a strobe and hold between strobes
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      opnd0_r        <= opnd0_val;
      opnd1_r        <= opnd1_val;
      dest0_kind     <= dest0_kind_d;
      dest1_kind     <= dest1_kind_d;
      dest0_sel      <= dest0_sel_d;
      dest1_sel      <= dest1_sel_d;
      instr_body_len <= body_len;
    end
  end

endmodule

//--- operand_decoder.sv
`timescale 1ns/1ps

module operand_decoder #(
  parameter int INSTR_BYTES = 11
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     instr_valid,
  input  logic [INSTR_BYTES*8-1:0] instr,
  input  opnd_pkg::opnd_form_t     opnd_form,
  input  logic                     imm_1byte,
  input  logic                     is_lea,
  input  logic                     opnd0_is_write,
  input  logic                     opnd1_is_write,
  input  opnd_pkg::word_t          eax,
  input  opnd_pkg::word_t          ecx,
  input  opnd_pkg::word_t          edx,
  input  opnd_pkg::word_t          ebx,
  input  opnd_pkg::word_t          esp,
  input  opnd_pkg::word_t          ebp,
  input  opnd_pkg::word_t          esi,
  input  opnd_pkg::word_t          edi,
  input  logic                     hint1_is_write,
  input  opnd_pkg::word_t          hint1_address,
  input  opnd_pkg::word_t          hint1_data,
  input  logic                     hint2_is_write,
  input  opnd_pkg::word_t          hint2_address,
  input  opnd_pkg::word_t          hint2_data,
  output logic                     out_valid,
  output opnd_pkg::word_t          opnd0_r,
  output opnd_pkg::word_t          opnd1_r,
  output opnd_pkg::dest_kind_t     dest0_kind,
  output opnd_pkg::dest_kind_t     dest1_kind,
  output opnd_pkg::word_t          dest0_sel,
  output opnd_pkg::word_t          dest1_sel,
  output logic [3:0]               instr_body_len
);
  import opnd_pkg::*;

  logic [7:0] modrm;
  logic [7:0] sib;
  word_t      disp;
  word_t      imm;
  logic       has_sib;
  logic       rm_is_direct;
  logic       disp_is_absolute;
  logic [3:0] body_len;
  word_t      mem_addr;
  word_t      mem_value;
  reg_sel_t   opnd0_regsel;
  reg_sel_t   opnd1_regsel;
  word_t      opnd0_regval;
  word_t      opnd1_regval;

  // Field extraction and length
  modrm_fields #(.INSTR_BYTES(INSTR_BYTES)) modrm_fields_inst (
    .instr(instr), .opnd_form(opnd_form), .imm_1byte(imm_1byte),
    .modrm(modrm), .sib(sib), .disp(disp), .imm(imm), .has_sib(has_sib),
    .rm_is_direct(rm_is_direct), .disp_is_absolute(disp_is_absolute), .body_len(body_len)
  );

  // Register operands, with the opcode's low bits for the REG forms
  reg_operand_select reg_operand_select_inst (
    .instr_low(instr[2:0]), .opnd_form(opnd_form), .modrm(modrm),
    .rm_is_direct(rm_is_direct),
    .eax(eax), .ecx(ecx), .edx(edx), .ebx(ebx), .esp(esp), .ebp(ebp), .esi(esi), .edi(edi),
    .opnd0_regsel(opnd0_regsel), .opnd1_regsel(opnd1_regsel),
    .opnd0_regval(opnd0_regval), .opnd1_regval(opnd1_regval)
  );

  // Single AGU for the ModR/M memory operand
  effective_address effective_address_inst (
    .modrm(modrm), .sib(sib), .has_sib(has_sib), .disp_is_absolute(disp_is_absolute),
    .disp(disp),
    .eax(eax), .ecx(ecx), .edx(edx), .ebx(ebx), .esp(esp), .ebp(ebp), .esi(esi), .edi(edi),
    .mem_addr(mem_addr)
  );

  mem_hint_match mem_hint_match_inst (
    .mem_addr(mem_addr),
    .hint1_is_write(hint1_is_write), .hint1_address(hint1_address), .hint1_data(hint1_data),
    .hint2_is_write(hint2_is_write), .hint2_address(hint2_address), .hint2_data(hint2_data),
    .mem_value(mem_value)
  );

  // Final muxing and the one pipeline register
  operand_select operand_select_inst (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .opnd_form(opnd_form),
    .is_lea(is_lea), .opnd0_is_write(opnd0_is_write), .opnd1_is_write(opnd1_is_write),
    .rm_is_direct(rm_is_direct), .imm(imm),
    .opnd0_regsel(opnd0_regsel), .opnd1_regsel(opnd1_regsel),
    .opnd0_regval(opnd0_regval), .opnd1_regval(opnd1_regval),
    .mem_addr(mem_addr), .mem_value(mem_value), .body_len(body_len),
    .out_valid(out_valid), .opnd0_r(opnd0_r), .opnd1_r(opnd1_r),
    .dest0_kind(dest0_kind), .dest1_kind(dest1_kind),
    .dest0_sel(dest0_sel), .dest1_sel(dest1_sel), .instr_body_len(instr_body_len)
  );

endmodule

//--- tb_operand_model.svh
`ifndef TB_OPERAND_MODEL_SVH
`define TB_OPERAND_MODEL_SVH

// x86 widens disp8 and imm8 by reading the byte as a signed value
function automatic word_t sign_extend8(input logic [7:0] b);
  // A byte with bit 7 set stands for its unsigned value minus 256
  return b[7] ? word_t'(b) - word_t'(256) : word_t'(b);
endfunction

// ModR/M is mod.reg.rm and SIB is scale.index.base, both 2+3+3 bits
function automatic logic [7:0] pack_fields(input logic [1:0] top, input reg_sel_t mid,
                                           input reg_sel_t low);
  return {top, mid, low};
endfunction

function automatic word_t reg_onehot(input reg_sel_t r);
  return word_t'(1) << r;
endfunction

// Opcode first, then ModR/M, SIB, displacement and immediate, little-endian
function automatic logic [INSTR_BYTES*8-1:0] encode_body(
    input logic [7:0] opcode, input bit use_modrm, input logic [7:0] modrm_byte,
    input bit use_sib, input logic [7:0] sib_byte, input int disp_len, input word_t disp_val,
    input int imm_len, input word_t imm_val);
  logic [INSTR_BYTES*8-1:0] body;
  int pos;
  // Unused tail bytes differ per position so an over-read shows up in the results
  for (int i = 0; i < INSTR_BYTES; i++) begin
    body[i*8 +: 8] = 8'h90 ^ 8'(i);
  end
  body[7:0] = opcode;
  pos = 1;
  if (use_modrm) begin
    body[pos*8 +: 8] = modrm_byte;
    pos++;
  end
  if (use_sib) begin
    body[pos*8 +: 8] = sib_byte;
    pos++;
  end
  for (int i = 0; i < disp_len; i++) begin
    body[(pos+i)*8 +: 8] = disp_val[i*8 +: 8];
  end
  pos += disp_len;
  for (int i = 0; i < imm_len; i++) begin
    body[(pos+i)*8 +: 8] = imm_val[i*8 +: 8];
  end
  return body;
endfunction

// Base plus index times scale factor plus displacement
// Mod 0 with base 5 has no base, and SIB index 4 has no index
function automatic word_t expect_address(input logic [1:0] mod, input bit use_sib,
                                         input reg_sel_t rm_field, input reg_sel_t base,
                                         input reg_sel_t index, input scale_t scale,
                                         input word_t disp);
  word_t b;
  word_t x;
  if (use_sib) begin
    b = (mod == 2'b00 && base == REG_EBP) ? '0 : regs[base];
    x = (index == REG_ESP) ? '0 : regs[index];
  end else begin
    b = (mod == 2'b00 && rm_field == REG_EBP) ? '0 : regs[rm_field];
    x = '0;
  end
  return b + x * (32'd1 << scale) + disp;
endfunction

// A read hint with the same address supplies the data, hint 1 first
function automatic word_t expect_hint(input word_t addr);
  if (!hint_w[0] && hint_a[0] == addr) return hint_d[0];
  if (!hint_w[1] && hint_a[1] == addr) return hint_d[1];
  return '0;
endfunction

`endif

//--- tb_operand_decoder.sv
`timescale 1ns/1ps

module tb_operand_decoder;
  import opnd_pkg::*;

  localparam int INSTR_BYTES = 11;
  localparam int CLK_PERIOD = 20;
  // Ten cycles per directed test on top of the reset time
  localparam int N_TESTS = 19;
  localparam int WATCHDOG_CYCLES = N_TESTS * 10 + 4;

  logic clk, rst_n, instr_valid, imm_1byte, is_lea, opnd0_is_write, opnd1_is_write;
  logic [INSTR_BYTES*8-1:0] instr;
  opnd_form_t opnd_form;
  word_t eax, ecx, edx, ebx, esp, ebp, esi, edi;
  logic hint1_is_write, hint2_is_write;
  word_t hint1_address, hint1_data, hint2_address, hint2_data;
  logic out_valid;
  word_t opnd0_r, opnd1_r, dest0_sel, dest1_sel;
  dest_kind_t dest0_kind, dest1_kind;
  logic [3:0] instr_body_len;

  // Register and hint images, shared by the drivers and the expected values
  word_t regs [8];
  logic hint_w [2];
  word_t hint_a [2];
  word_t hint_d [2];
  integer seed = 64;

  `include "tb_operand_model.svh"

  operand_decoder #(.INSTR_BYTES(INSTR_BYTES)) operand_decoder_inst (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the directed tests finished");
    $display("tests failed");
    $fatal(1);
  end

  task automatic report_mismatch(input string name, input string field, input word_t exp,
                                 input word_t act);
    $display("error: %s %s expected %h actual %h", name, field, exp, act);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("error: %s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input string field, input word_t exp,
                            input word_t act);
    assert (act === exp) else report_mismatch(name, field, exp, act);
  endtask

  task automatic randomize_regs();
    for (int i = 0; i < 8; i++) begin
      regs[i] = $random(seed);
    end
  endtask

  // A missing hint keeps an address near the real one so only equality decides
  task automatic set_hints(input word_t addr, input bit w1, input bit hit1, input bit w2,
                           input bit hit2);
    hint_w[0] = w1;
    hint_w[1] = w2;
    hint_a[0] = hit1 ? addr : addr ^ 32'h0000_1000;
    hint_a[1] = hit2 ? addr : addr ^ 32'h0000_2000;
    hint_d[0] = $random(seed);
    hint_d[1] = $random(seed);
  endtask

  task automatic drive_inputs(input logic [INSTR_BYTES*8-1:0] body, input opnd_form_t form,
                              input bit imm1, input bit lea, input bit w0, input bit w1);
    instr_valid <= 1'b1;
    instr <= body;
    opnd_form <= form;
    imm_1byte <= imm1;
    is_lea <= lea;
    opnd0_is_write <= w0;
    opnd1_is_write <= w1;
    {eax, ecx, edx, ebx} <= {regs[0], regs[1], regs[2], regs[3]};
    {esp, ebp, esi, edi} <= {regs[4], regs[5], regs[6], regs[7]};
    {hint1_is_write, hint1_address, hint1_data} <= {hint_w[0], hint_a[0], hint_d[0]};
    {hint2_is_write, hint2_address, hint2_data} <= {hint_w[1], hint_a[1], hint_d[1]};
  endtask

  // One strobe: inputs set on one edge, sampled by the DUT on the next
  task automatic apply_strobe(input logic [INSTR_BYTES*8-1:0] body, input opnd_form_t form,
                              input bit imm1, input bit lea, input bit w0, input bit w1);
    @(posedge clk);
    drive_inputs(body, form, imm1, lea, w0, w1);
    @(posedge clk);
    instr_valid <= 1'b0;
  endtask

  task automatic wait_result(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_valid && cycles < 4) begin
      @(negedge clk);
      cycles++;
    end
    assert (out_valid) else report_failure($sformatf("%s got no out_valid strobe", name));
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    assert (out_valid === 1'b0) else report_failure("out_valid was high right after reset");
  endtask

  task automatic test_reg_direct(input string name, input opnd_form_t form,
                                 input reg_sel_t reg_field, input reg_sel_t rm_field);
    reg_sel_t r0;
    reg_sel_t r1;
    randomize_regs();
    set_hints(32'h0, 0, 0, 0, 0);
    r0 = (form == FORM_MODRM_RM_REG) ? rm_field : reg_field;
    r1 = (form == FORM_MODRM_RM_REG) ? reg_field : rm_field;
    apply_strobe(encode_body(8'h89, 1, pack_fields(2'b11, reg_field, rm_field), 0, 8'h00, 0,
                             '0, 0, '0), form, 0, 0, 1, 0);
    wait_result(name);
    check_word(name, "opnd0", regs[r0], opnd0_r);
    check_word(name, "opnd1", regs[r1], opnd1_r);
    check_word(name, "dest0_kind", DEST_REG, dest0_kind);
    check_word(name, "dest0_sel", reg_onehot(r0), dest0_sel);
    check_word(name, "dest1_kind", DEST_NONE, dest1_kind);
    check_word(name, "dest1_sel", '0, dest1_sel);
    check_word(name, "body_len", 1, instr_body_len);
  endtask

  task automatic test_imm(input string name, input opnd_form_t form, input logic [7:0] opcode,
                          input bit imm1, input word_t imm_val);
    reg_sel_t r0;
    word_t exp_imm;
    randomize_regs();
    set_hints(32'h0, 0, 0, 0, 0);
    // The EAX form ignores the opcode's low bits
    r0 = (form == FORM_EAX_IMM) ? REG_EAX : opcode[2:0];
    exp_imm = imm1 ? sign_extend8(imm_val[7:0]) : imm_val;
    apply_strobe(encode_body(opcode, 0, 8'h00, 0, 8'h00, 0, '0, imm1 ? 1 : 4, imm_val),
                 form, imm1, 0, 1, 0);
    wait_result(name);
    check_word(name, "opnd0", regs[r0], opnd0_r);
    check_word(name, "opnd1", exp_imm, opnd1_r);
    check_word(name, "dest0_sel", reg_onehot(r0), dest0_sel);
    check_word(name, "body_len", imm1 ? 1 : 4, instr_body_len);
  endtask

  task automatic test_mem(input string name, input logic [1:0] mod, input reg_sel_t rm_field,
                          input reg_sel_t reg_field, input word_t disp, input bit w1,
                          input bit hit1, input bit w2, input bit hit2);
    word_t addr;
    int dlen;
    randomize_regs();
    dlen = (mod == 2'b01) ? 1 : 4;
    addr = expect_address(mod, 0, rm_field, 0, 0, 0, (dlen == 1) ? sign_extend8(disp[7:0]) : disp);
    set_hints(addr, w1, hit1, w2, hit2);
    apply_strobe(encode_body(8'h89, 1, pack_fields(mod, reg_field, rm_field), 0, 8'h00, dlen,
                             disp, 0, '0), FORM_MODRM_RM_REG, 0, 0, 1, 0);
    wait_result(name);
    check_word(name, "opnd0", expect_hint(addr), opnd0_r);
    check_word(name, "opnd1", regs[reg_field], opnd1_r);
    check_word(name, "dest0_kind", DEST_MEM, dest0_kind);
    check_word(name, "dest0_sel", addr, dest0_sel);
    check_word(name, "body_len", 1 + dlen, instr_body_len);
  endtask

  task automatic test_sib(input string name, input logic [1:0] mod, input scale_t scale,
                          input reg_sel_t index, input reg_sel_t base, input word_t disp);
    word_t addr;
    int dlen;
    randomize_regs();
    // Mod 0 carries a disp32 only when the base field is 5
    dlen = (mod == 2'b01) ? 1 : (mod == 2'b10 || base == REG_EBP) ? 4 : 0;
    addr = expect_address(mod, 1, REG_ESP, base, index, scale,
                          (dlen == 1) ? sign_extend8(disp[7:0]) : (dlen == 4) ? disp : '0);
    set_hints(addr, 0, 1, 0, 0);
    apply_strobe(encode_body(8'h89, 1, pack_fields(mod, REG_EDX, REG_ESP), 1,
                             pack_fields(scale, index, base), dlen, disp, 0, '0),
                 FORM_MODRM_RM_REG, 0, 0, 1, 0);
    wait_result(name);
    check_word(name, "dest0_sel", addr, dest0_sel);
    check_word(name, "opnd0", hint_d[0], opnd0_r);
    check_word(name, "body_len", 2 + dlen, instr_body_len);
  endtask

  // LEA edx, [ebx + disp32] hands back the address, not the missing memory data
  task automatic test_lea();
    word_t addr;
    randomize_regs();
    addr = expect_address(2'b10, 0, REG_EBX, 0, 0, 0, 32'h0000_2468);
    set_hints(addr, 0, 0, 0, 0);
    apply_strobe(encode_body(8'h8D, 1, pack_fields(2'b10, REG_EDX, REG_EBX), 0, 8'h00, 4,
                             32'h0000_2468, 0, '0), FORM_MODRM_REG_RM, 0, 1, 1, 0);
    wait_result("lea");
    check_word("lea", "opnd1", addr, opnd1_r);
    check_word("lea", "opnd0", regs[REG_EDX], opnd0_r);
    check_word("lea", "dest0_sel", reg_onehot(REG_EDX), dest0_sel);
    check_word("lea", "body_len", 5, instr_body_len);
  endtask

  // Two strobes on adjacent edges, then one idle edge
  task automatic test_back_to_back();
    word_t first_imm;
    word_t second_imm;
    randomize_regs();
    first_imm = $random(seed);
    second_imm = $random(seed);
    @(posedge clk);
    drive_inputs(encode_body(8'h05, 0, 8'h00, 0, 8'h00, 0, '0, 4, first_imm),
                 FORM_EAX_IMM, 0, 0, 0, 0);
    @(posedge clk);
    drive_inputs(encode_body(8'h05, 0, 8'h00, 0, 8'h00, 0, '0, 1, second_imm),
                 FORM_EAX_IMM, 1, 0, 0, 0);
    @(negedge clk);
    assert (out_valid === 1'b1) else report_failure("first back-to-back strobe was lost");
    check_word("back_to_back_1", "opnd1", first_imm, opnd1_r);
    @(posedge clk);
    instr_valid <= 1'b0;
    // The idle edge sees different bytes, so a register loading without the strobe would change
    instr <= ~instr;
    @(negedge clk);
    assert (out_valid === 1'b1) else report_failure("second back-to-back strobe was lost");
    check_word("back_to_back_2", "opnd1", sign_extend8(second_imm[7:0]), opnd1_r);
    check_word("back_to_back_2", "body_len", 1, instr_body_len);
    @(negedge clk);
    assert (out_valid === 1'b0) else report_failure("out_valid was high in an idle cycle");
    check_word("idle_hold", "opnd1", sign_extend8(second_imm[7:0]), opnd1_r);
  endtask

  initial begin
    rst_n = 1'b0;
    // The strobe stays high through reset so that only the reset holds out_valid low
    instr_valid = 1'b1;
    instr = '0;
    opnd_form = '0;
    {imm_1byte, is_lea, opnd0_is_write, opnd1_is_write} = 4'b0000;
    {eax, ecx, edx, ebx, esp, ebp, esi, edi} = '0;
    {hint1_is_write, hint1_address, hint1_data} = '0;
    {hint2_is_write, hint2_address, hint2_data} = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    instr_valid <= 1'b0;
    test_reset_state();
    test_reg_direct("rm_reg_direct", FORM_MODRM_RM_REG, REG_ECX, REG_ESI);
    test_reg_direct("reg_rm_direct", FORM_MODRM_REG_RM, REG_EDI, REG_EDX);
    test_imm("reg_imm8", FORM_REG_IMM, 8'hB3, 1, 32'h0000_0080);
    test_imm("reg_imm32", FORM_REG_IMM, 8'hBE, 0, 32'h8765_4321);
    test_imm("eax_imm8", FORM_EAX_IMM, 8'h05, 1, 32'h0000_007F);
    test_imm("eax_imm32", FORM_EAX_IMM, 8'h05, 0, 32'h1357_9BDF);
    test_mem("mem_disp8_hint1", 2'b01, REG_EBX, REG_EAX, 32'h0000_00F8, 0, 1, 0, 0);
    test_mem("mem_disp32_hint2", 2'b10, REG_EBP, REG_ECX, 32'h0001_2340, 0, 0, 0, 1);
    test_mem("mem_both_hints", 2'b01, REG_ESI, REG_EDX, 32'h0000_0010, 0, 1, 0, 1);
    test_mem("mem_write_hint_miss", 2'b10, REG_EDI, REG_EBX, 32'hFFFF_FF00, 1, 1, 0, 0);
    test_sib("sib_scale1", 2'b01, 2'd0, REG_ESI, REG_EBX, 32'h0000_0004);
    test_sib("sib_scale2", 2'b01, 2'd1, REG_ECX, REG_EAX, 32'h0000_00F0);
    test_sib("sib_scale4", 2'b01, 2'd2, REG_EDI, REG_ESP, 32'h0000_007F);
    test_sib("sib_scale8", 2'b01, 2'd3, REG_EBP, REG_EDX, 32'h0000_0080);
    test_sib("sib_no_index", 2'b10, 2'd3, REG_ESP, REG_ECX, 32'h1234_5678);
    test_sib("sib_no_base", 2'b00, 2'd2, REG_EDI, REG_EBP, 32'h0040_0000);
    test_lea();
    test_back_to_back();
    $display("all tests passed");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
opnd_pkg.sv
modrm_fields.sv
reg_operand_select.sv
effective_address.sv
mem_hint_match.sv
operand_select.sv
operand_decoder.sv
tb_operand_decoder.sv

//--- Bender.yml
package:
  name: operand_decoder

sources:
  - files:
      - opnd_pkg.sv
      - modrm_fields.sv
      - reg_operand_select.sv
      - effective_address.sv
      - mem_hint_match.sv
      - operand_select.sv
      - operand_decoder.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_operand_decoder.sv
